/* project.f */
logic/uart_line_pkg.sv
logic/cmd_pkg.sv
logic/hold_stage.sv
logic/cmd_serializer.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_cmd_bridge.sv
bench/uart_cmd_bridge_properties.sv
bench/uart_cmd_bridge_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module uart_cmd_bridge_tb -Mdir obj_dir -o uart_cmd_bridge_sim
	./obj_dir/uart_cmd_bridge_sim

clean:
	rm -rf obj_dir

/* bench/uart_cmd_bridge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_bridge_tb;

  localparam int n_single     = 4;
  localparam int n_burst      = 20;
  localparam int n_rx_good    = 16;
  localparam int n_rx_bad     = 4;
  localparam int n_overrun    = 5;
  localparam int bit_cycles   = uart_line_pkg::clks_per_bit;
  localparam int frame_cycles = uart_line_pkg::frame_bits * bit_cycles;
  localparam int total_frames = 2 * (n_single + n_burst) + n_rx_good + n_rx_bad + n_overrun;
  localparam int cycle_limit  = total_frames * frame_cycles * 2 + 2000;

  logic                clk;
  logic                rst_n;
  cmd_pkg::cmd_word_t  cmd_in;
  logic                cmd_valid;
  logic                cmd_ready;
  logic                rx;
  logic                tx;
  cmd_pkg::read_word_t read_word;
  logic                read_valid;
  logic                read_ready;

  integer seed;
  integer stall_seed;
  int     cycles;
  int     stall_left;
  logic   hold_read;
  logic   rx_overrun;

  // expected bytes on tx and expected words at the read port
  uart_line_pkg::byte_t exp_tx[$];
  cmd_pkg::read_word_t  exp_rd[$];

  uart_cmd_bridge u_uart_cmd_bridge (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .rx         (rx),
    .tx         (tx),
    .read_word  (read_word),
    .read_valid (read_valid),
    .read_ready (read_ready)
  );

  always #50 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s at %0t ns", why, $time);
    $display("Testbench failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_eq(input logic [15:0] actual, input logic [15:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic send_cmd(input cmd_pkg::cmd_word_t value);
    cmd_in    = value;
    cmd_valid = 1'b1;
    while (!cmd_ready) @(negedge clk);
    @(posedge clk);
    exp_tx.push_back(value.hi);
    exp_tx.push_back(value.lo);
    @(negedge clk);
  endtask

  // drives one frame on rx, dropped frames only raise the overrun flag
  task automatic send_frame(input uart_line_pkg::byte_t data, input logic bad_par,
                            input logic dropped);
    logic [uart_line_pkg::frame_bits-1:0] bits;
    cmd_pkg::read_word_t                  word;
    bits = {1'b1, (~^data) ^ bad_par, data, 1'b0};
    if (dropped) begin
      rx_overrun = 1'b1;
    end else begin
      word.overrun    = rx_overrun;
      word.parity_err = bad_par;
      word.data       = data;
      exp_rd.push_back(word);
      rx_overrun = 1'b0;
    end
    for (int i = 0; i < uart_line_pkg::frame_bits; i++) begin
      rx = bits[i];
      repeat (bit_cycles) @(negedge clk);
    end
  endtask

  // read consumer with short random stalls
  always @(negedge clk) begin
    if (hold_read) begin
      read_ready = 1'b0;
    end else if (stall_left > 0) begin
      read_ready = 1'b0;
      stall_left = stall_left - 1;
    end else begin
      read_ready = 1'b1;
      if (($random(stall_seed) & 7) == 0) stall_left = 1 + ($random(stall_seed) & 63);
    end
    // word is taken at the coming rising edge
    if (read_valid && read_ready) begin
      if (exp_rd.size() == 0) abort_run("read word delivered with none expected");
      else check_eq(16'(read_word), 16'(exp_rd.pop_front()), "read word");
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) abort_run($sformatf("timeout after %0d cycles", cycles));
  end

  // tx decoder, samples each bit at its middle
  initial begin : tx_monitor
    logic [uart_line_pkg::frame_bits-1:0] bits;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      if (tx === 1'b0) begin
        repeat (uart_line_pkg::half_bit) @(negedge clk);
        bits[0] = tx;
        for (int i = 1; i < uart_line_pkg::frame_bits; i++) begin
          repeat (bit_cycles) @(negedge clk);
          bits[i] = tx;
        end
        check_eq(16'(bits[0]), 16'd0, "tx start bit");
        check_eq(16'(bits[uart_line_pkg::frame_bits-1]), 16'd1, "tx stop bit");
        check_eq(16'(^bits[uart_line_pkg::data_bits+1:1]), 16'd1, "tx odd parity");
        if (exp_tx.size() == 0) abort_run("tx frame sent with no command pending");
        else check_eq(16'(bits[uart_line_pkg::data_bits:1]), 16'(exp_tx.pop_front()),
                      "tx data byte");
      end
    end
  end

  initial begin
    int gap;
    seed       = 32'h10171fbe;
    stall_seed = 32'h10171fbe;
    clk        = 1'b0;
    rst_n      = 1'b0;
    cmd_in     = '0;
    cmd_valid  = 1'b0;
    rx         = 1'b1;
    read_ready = 1'b0;
    hold_read  = 1'b1;
    rx_overrun = 1'b0;
    stall_left = 0;
    cycles     = 0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    repeat (5) begin
      @(negedge clk);
      check_eq(16'(tx), 16'd1, "tx idle after reset");
      check_eq(16'(cmd_ready), 16'd1, "cmd_ready after reset");
      check_eq(16'(read_valid), 16'd0, "read_valid after reset");
    end

    // read consumer starts here
    @(posedge clk);
    hold_read = 1'b0;
    @(negedge clk);

    // single commands, line drained between them
    for (int n = 0; n < n_single; n++) begin
      send_cmd(16'($random(seed)));
      cmd_valid = 1'b0;
      while (exp_tx.size() != 0) @(posedge clk);
      @(negedge clk);
    end

    // burst throttled by cmd_ready
    for (int n = 0; n < n_burst; n++) begin
      send_cmd(16'($random(seed)));
      gap = $random(seed) & 3;
      if (gap != 0) begin
        cmd_valid = 1'b0;
        repeat (gap) @(negedge clk);
      end
    end
    cmd_valid = 1'b0;
    while (exp_tx.size() != 0) @(posedge clk);
    @(negedge clk);

    for (int n = 0; n < n_rx_good; n++) begin
      send_frame(8'($random(seed)), 1'b0, 1'b0);
      repeat (2 + ($random(seed) & 7)) @(negedge clk);
    end
    for (int n = 0; n < n_rx_bad; n++) begin
      send_frame(8'($random(seed)), 1'b1, 1'b0);
      repeat (4) @(negedge clk);
    end
    while (exp_rd.size() != 0) @(posedge clk);

    // consumer stalled, second and third frames find the buffer full
    @(posedge clk);
    hold_read = 1'b1;
    @(negedge clk);
    send_frame(8'($random(seed)), 1'b0, 1'b0);
    repeat (4) @(negedge clk);
    send_frame(8'($random(seed)), 1'b0, 1'b1);
    repeat (4) @(negedge clk);
    send_frame(8'($random(seed)), 1'b0, 1'b1);
    repeat (4) @(negedge clk);
    @(posedge clk);
    hold_read = 1'b0;
    @(negedge clk);
    send_frame(8'($random(seed)), 1'b0, 1'b0);
    repeat (4) @(negedge clk);
    send_frame(8'($random(seed)), 1'b0, 1'b0);
    while (exp_rd.size() != 0) @(posedge clk);
    repeat (20) @(negedge clk);

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/uart_cmd_bridge_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_bridge_properties (
  input logic                clk,
  input logic                rst_n,
  input cmd_pkg::cmd_word_t  cmd_in,
  input logic                cmd_valid,
  input logic                cmd_ready,
  input logic                tx,
  input logic                byte_ready,
  input cmd_pkg::read_word_t read_word,
  input logic                read_valid,
  input logic                read_ready
);

  // stalled handshakes hold valid and payload
  assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_in))
    else $error("command dropped or changed while stalled");

  assert property (@(posedge clk) disable iff (!rst_n)
    read_valid && !read_ready |=> read_valid && $stable(read_word))
    else $error("read word dropped or changed while stalled");

  // transmitter ready means the line is idle
  assert property (@(posedge clk) disable iff (!rst_n) byte_ready |-> tx)
    else $error("tx low while transmitter idle");

  assert property (@(posedge clk) $rose(rst_n) |-> !read_valid)
    else $error("read_valid high right after reset");

  assert property (@(posedge clk) $rose(rst_n) |-> cmd_ready)
    else $error("cmd_ready low right after reset");

endmodule

bind uart_cmd_bridge uart_cmd_bridge_properties u_properties (
  .clk        (clk),
  .rst_n      (rst_n),
  .cmd_in     (cmd_in),
  .cmd_valid  (cmd_valid),
  .cmd_ready  (cmd_ready),
  .tx         (tx),
  .byte_ready (byte_ready),
  .read_word  (read_word),
  .read_valid (read_valid),
  .read_ready (read_ready)
);

`default_nettype wire

/* logic/uart_cmd_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_bridge (
  input  logic                clk,
  input  logic                rst_n,
  input  cmd_pkg::cmd_word_t  cmd_in,
  input  logic                cmd_valid,
  output logic                cmd_ready,
  input  logic                rx,
  output logic                tx,
  output cmd_pkg::read_word_t read_word,
  output logic                read_valid,
  input  logic                read_ready
);

  cmd_pkg::cmd_word_t   cmd_word;
  logic                 cmd_word_valid;
  logic                 cmd_word_ready;
  uart_line_pkg::byte_t byte_out;
  logic                 byte_valid;
  logic                 byte_ready;
  cmd_pkg::read_word_t  rd_word;
  logic                 rd_strobe;
  logic                 rd_space;

  // command path
  hold_stage #(
    .payload_t (cmd_pkg::cmd_word_t)
  ) u_cmd_hold (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (cmd_in),
    .in_valid  (cmd_valid),
    .in_ready  (cmd_ready),
    .out_data  (cmd_word),
    .out_valid (cmd_word_valid),
    .out_ready (cmd_word_ready)
  );

  cmd_serializer u_serializer (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_word       (cmd_word),
    .cmd_word_valid (cmd_word_valid),
    .cmd_word_ready (cmd_word_ready),
    .byte_out       (byte_out),
    .byte_valid     (byte_valid),
    .byte_ready     (byte_ready)
  );

  uart_tx u_tx (
    .clk        (clk),
    .rst_n      (rst_n),
    .byte_in    (byte_out),
    .byte_valid (byte_valid),
    .byte_ready (byte_ready),
    .tx         (tx)
  );

  // receive path
  uart_rx u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rd_word   (rd_word),
    .rd_strobe (rd_strobe),
    .rd_space  (rd_space)
  );

  hold_stage #(
    .payload_t (cmd_pkg::read_word_t)
  ) u_read_hold (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (rd_word),
    .in_valid  (rd_strobe),
    .in_ready  (rd_space),
    .out_data  (read_word),
    .out_valid (read_valid),
    .out_ready (read_ready)
  );

endmodule

`default_nettype wire

/* logic/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rx,
  output cmd_pkg::read_word_t rd_word,
  output logic                rd_strobe,
  input  logic                rd_space
);

  typedef enum logic [1:0] {
    s_idle,
    s_start,
    s_bits
  } state_t;

  state_t                              state;
  logic                                rx_meta;
  logic                                rx_sync;
  logic                                rx_prev;
  logic [uart_line_pkg::clk_cnt_w-1:0] clk_cnt;
  logic [uart_line_pkg::bit_idx_w-1:0] bit_cnt;
  uart_line_pkg::byte_t                data_q;
  logic                                par_q;
  logic                                overrun_q;
  logic                                half_hit;
  logic                                bit_hit;
  logic                                stop_bit;

  assign half_hit = (clk_cnt == uart_line_pkg::clk_cnt_w'(uart_line_pkg::half_bit - 1));
  assign bit_hit  = (clk_cnt == uart_line_pkg::clk_cnt_w'(uart_line_pkg::clks_per_bit - 1));
  assign stop_bit = (bit_cnt == uart_line_pkg::bit_idx_w'(uart_line_pkg::data_bits + 1));

  // strobe in the stop sample cycle, bad stop bit drops the frame
  assign rd_strobe = (state == s_bits) && bit_hit && stop_bit && rx_sync;

  assign rd_word.overrun    = overrun_q;
  assign rd_word.parity_err = ~^{data_q, par_q};
  assign rd_word.data       = data_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= s_idle;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      case (state)
        s_idle: begin
          if (rx_prev && !rx_sync) begin
            state   <= s_start;
            clk_cnt <= '0;
          end
        end
        s_start: begin
          if (half_hit) begin
            // glitch if the line is back high at mid start bit
            state   <= rx_sync ? s_idle : s_bits;
            clk_cnt <= '0;
            bit_cnt <= '0;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        s_bits: begin
          if (bit_hit) begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (stop_bit) state <= s_idle;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == s_bits && bit_hit) begin
      if (bit_cnt < uart_line_pkg::bit_idx_w'(uart_line_pkg::data_bits)) begin
        data_q <= {rx_sync, data_q[uart_line_pkg::data_bits-1:1]};
      end else if (!stop_bit) begin
        par_q <= rx_sync;
      end
    end
  end

  // sticky until a word carrying it is accepted
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      overrun_q <= 1'b0;
    end else if (rd_strobe) begin
      overrun_q <= !rd_space;
    end
  end

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_line_pkg::byte_t byte_in,
  input  logic                 byte_valid,
  output logic                 byte_ready,
  output logic                 tx
);

  logic                                busy;
  logic [uart_line_pkg::frame_bits-1:0] shift_q;
  logic [uart_line_pkg::clk_cnt_w-1:0]  clk_cnt;
  logic [uart_line_pkg::bit_idx_w-1:0]  bit_cnt;
  logic                                bit_end;
  logic                                frame_done;

  assign byte_ready = !busy;

  // shift register idles at all ones, so the line sits high
  assign tx = shift_q[0];

  assign bit_end    = (clk_cnt == uart_line_pkg::clk_cnt_w'(uart_line_pkg::clks_per_bit - 1));
  assign frame_done = (bit_cnt == uart_line_pkg::bit_idx_w'(uart_line_pkg::frame_bits));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      shift_q <= '1;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (!busy) begin
      if (byte_valid) begin
        busy    <= 1'b1;
        // stop, odd parity, data lsb first, start
        shift_q <= {1'b1, ~^byte_in, byte_in, 1'b0};
        clk_cnt <= '0;
        bit_cnt <= '0;
      end
    end else if (frame_done) begin
      // one spare cycle after the stop bit before ready returns
      busy <= 1'b0;
    end else if (bit_end) begin
      clk_cnt <= '0;
      bit_cnt <= bit_cnt + 1'b1;
      shift_q <= {1'b1, shift_q[uart_line_pkg::frame_bits-1:1]};
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/cmd_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_serializer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cmd_pkg::cmd_word_t   cmd_word,
  input  logic                 cmd_word_valid,
  output logic                 cmd_word_ready,
  output uart_line_pkg::byte_t byte_out,
  output logic                 byte_valid,
  input  logic                 byte_ready
);

  typedef enum logic [1:0] {
    s_idle,
    s_hi,
    s_lo
  } state_t;

  state_t             state;
  cmd_pkg::cmd_word_t cmd_q;

  assign cmd_word_ready = (state == s_idle);
  assign byte_valid     = (state != s_idle);

  // hi byte first, then lo
  assign byte_out = (state == s_hi) ? cmd_q.hi : cmd_q.lo;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= s_idle;
    end else begin
      case (state)
        s_idle: if (cmd_word_valid) state <= s_hi;
        s_hi:   if (byte_ready) state <= s_lo;
        s_lo:   if (byte_ready) state <= s_idle;
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_word_valid && cmd_word_ready) begin
      cmd_q <= cmd_word;
    end
  end

endmodule

`default_nettype wire

/* logic/hold_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module hold_stage #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  logic     full;
  payload_t slot;

  // accept when empty, or when the held word leaves this cycle
  assign in_ready  = !full || out_ready;
  assign out_valid = full;
  assign out_data  = slot;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (in_valid && in_ready) begin
      full <= 1'b1;
    end else if (full && out_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      slot <= in_data;
    end
  end

endmodule

`default_nettype wire

/* logic/cmd_pkg.sv */
`default_nettype none

package cmd_pkg;

  // 16-bit command, hi byte goes out on the line first
  typedef struct packed {
    uart_line_pkg::byte_t hi;
    uart_line_pkg::byte_t lo;
  } cmd_word_t;

  // one received frame as seen by the consumer
  typedef struct packed {
    logic                 overrun;
    logic                 parity_err;
    uart_line_pkg::byte_t data;
  } read_word_t;

endpackage

`default_nettype wire

/* logic/uart_line_pkg.sv */
`default_nettype none

package uart_line_pkg;

  // bit period in clk cycles, short for simulation
  localparam int clks_per_bit = 16;

  // sample point of the start bit, counted from the first low sample
  localparam int half_bit = clks_per_bit / 2;

  localparam int data_bits = 8;

  // start, data, odd parity, stop
  localparam int frame_bits = data_bits + 3;

  // counter widths shared by tx and rx
  localparam int clk_cnt_w = $clog2(clks_per_bit);
  localparam int bit_idx_w = $clog2(frame_bits + 1);

  typedef logic [data_bits-1:0] byte_t;

endpackage

`default_nettype wire
